// File: design/vp8_enc_defines.svh
`ifndef VP8_ENC_DEFINES_SVH
`define VP8_ENC_DEFINES_SVH

// ----------------------------------------
// Quantizer constants
// ----------------------------------------
`define VP8_QFIX        17
`define VP8_MAX_LEVEL   2047

// ----------------------------------------
// Transform multipliers
// ----------------------------------------
`define VP8_FDCT_K1     2217
`define VP8_FDCT_K2     5352
`define VP8_IDCT_C1     (20091 + 65536)
`define VP8_IDCT_C2     35468

// Matrix select codes for the config port
`define VP8_QF_Q        3'd0
`define VP8_QF_IQ       3'd1
`define VP8_QF_BIAS     3'd2
`define VP8_QF_ZTHRESH  3'd3
`define VP8_QF_SHARPEN  3'd4

`endif

// File: design/vp8_enc_pkg.sv
package vp8_enc_pkg;

    // ----------------------------------------
    // Pixel and block containers
    // ----------------------------------------

    // Unsigned luma sample
    typedef logic [7:0] pixel_t;

    // 16 pixels in raster order, pixel 0 in bits 7:0
    typedef logic [127:0] pix_blk_t;

    // Transform domain value
    typedef logic signed [15:0] coeff_t;

    // 16 coefficients in raster order
    typedef logic [255:0] coeff_blk_t;

    // 16 levels in zigzag scan order
    typedef logic [255:0] level_blk_t;

    // ----------------------------------------
    // Quantizer matrix fields
    // ----------------------------------------
    typedef logic [15:0] qmul_t;
    typedef logic [31:0] qwide_t;
    typedef logic [2:0]  qfield_t;
    typedef logic [3:0]  coef_idx_t;

endpackage

// File: design/quant_if.sv
`timescale 1ns/1ps

// Per-coefficient quantizer matrices, indexed in raster order
interface quant_if;

    vp8_enc_pkg::qmul_t  q       [16];
    vp8_enc_pkg::qmul_t  iq      [16];
    vp8_enc_pkg::qwide_t bias    [16];
    vp8_enc_pkg::qwide_t zthresh [16];
    vp8_enc_pkg::qmul_t  sharpen [16];

    // Register block side
    modport regs (
        output q,
        output iq,
        output bias,
        output zthresh,
        output sharpen
    );

    // Quantizer side
    modport quant (
        input  q,
        input  iq,
        input  bias,
        input  zthresh,
        input  sharpen
    );

endinterface

// File: design/quant_param_regs.sv
`timescale 1ns/1ps
`include "vp8_enc_defines.svh"

module quant_param_regs (
     input  logic                     clk_i
    ,input  logic                     rst_n_i
    ,input  logic                     cfg_we_i
    ,input  vp8_enc_pkg::qfield_t     cfg_field_i
    ,input  vp8_enc_pkg::coef_idx_t   cfg_idx_i
    ,input  vp8_enc_pkg::qwide_t      cfg_data_i
    ,quant_if.regs                    qp
);

    vp8_enc_pkg::qmul_t  q_r       [16];
    vp8_enc_pkg::qmul_t  iq_r      [16];
    vp8_enc_pkg::qwide_t bias_r    [16];
    vp8_enc_pkg::qwide_t zthresh_r [16];
    vp8_enc_pkg::qmul_t  sharpen_r [16];

    // One entry of one matrix per write strobe
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int k = 0; k < 16; k++) begin
                q_r[k]       <= '0;
                iq_r[k]      <= '0;
                bias_r[k]    <= '0;
                zthresh_r[k] <= '0;
                sharpen_r[k] <= '0;
            end
        end else if (cfg_we_i) begin
            case (cfg_field_i)
                `VP8_QF_Q:       q_r[cfg_idx_i]       <= cfg_data_i[15:0];
                `VP8_QF_IQ:      iq_r[cfg_idx_i]      <= cfg_data_i[15:0];
                `VP8_QF_BIAS:    bias_r[cfg_idx_i]    <= cfg_data_i;
                `VP8_QF_ZTHRESH: zthresh_r[cfg_idx_i] <= cfg_data_i;
                `VP8_QF_SHARPEN: sharpen_r[cfg_idx_i] <= cfg_data_i[15:0];
                default: begin
                end
            endcase
        end
    end

    assign qp.q       = q_r;
    assign qp.iq      = iq_r;
    assign qp.bias    = bias_r;
    assign qp.zthresh = zthresh_r;
    assign qp.sharpen = sharpen_r;

    // Software must only target the five defined matrices
    a_field_valid: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        cfg_we_i |-> (cfg_field_i <= `VP8_QF_SHARPEN)
    );

endmodule

// File: design/fdct_4x4.sv
`timescale 1ns/1ps
`include "vp8_enc_defines.svh"

module fdct_4x4 (
     input  logic                     clk_i
    ,input  logic                     rst_n_i
    ,input  logic                     start_i
    ,input  vp8_enc_pkg::pix_blk_t    src_i
    ,input  vp8_enc_pkg::pix_blk_t    pred_i
    ,output vp8_enc_pkg::coeff_blk_t  coeff_o
    ,output vp8_enc_pkg::pix_blk_t    pred_o
    ,output logic                     valid_o
);

    vp8_enc_pkg::coeff_t     h_c [16];
    vp8_enc_pkg::coeff_t     h_r [16];
    vp8_enc_pkg::coeff_blk_t v_c;
    vp8_enc_pkg::pix_blk_t   pred_s1;
    logic                    valid_s1;

    // ----------------------------------------
    // Stage 1: row pass on src - pred
    // ----------------------------------------
    always_comb begin : h_pass
        int d [4];
        int a0, a1, a2, a3;
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                d[c] = int'(src_i[8*(4*r+c) +: 8]) - int'(pred_i[8*(4*r+c) +: 8]);
            end
            a0 = d[0] + d[3];
            a1 = d[1] + d[2];
            a2 = d[1] - d[2];
            a3 = d[0] - d[3];
            h_c[4*r+0] = vp8_enc_pkg::coeff_t'((a0 + a1) * 8);
            h_c[4*r+1] = vp8_enc_pkg::coeff_t'(
                (a2 * `VP8_FDCT_K1 + a3 * `VP8_FDCT_K2 + 1812) >>> 9);
            h_c[4*r+2] = vp8_enc_pkg::coeff_t'((a0 - a1) * 8);
            h_c[4*r+3] = vp8_enc_pkg::coeff_t'(
                (a3 * `VP8_FDCT_K1 - a2 * `VP8_FDCT_K2 + 937) >>> 9);
        end
    end

    // ----------------------------------------
    // Stage 2: column pass
    // ----------------------------------------
    always_comb begin : v_pass
        int a0, a1, a2, a3;
        int odd1, odd3;
        for (int c = 0; c < 4; c++) begin
            a0 = int'(h_r[c]) + int'(h_r[12+c]);
            a1 = int'(h_r[4+c]) + int'(h_r[8+c]);
            a2 = int'(h_r[4+c]) - int'(h_r[8+c]);
            a3 = int'(h_r[c]) - int'(h_r[12+c]);
            // Row 1 gets a +1 bias whenever a3 is nonzero
            odd1 = ((a2 * `VP8_FDCT_K1 + a3 * `VP8_FDCT_K2 + 12000) >>> 16) + int'(a3 != 0);
            odd3 = (a3 * `VP8_FDCT_K1 - a2 * `VP8_FDCT_K2 + 51000) >>> 16;
            v_c[16*c +: 16]      = 16'((a0 + a1 + 7) >>> 4);
            v_c[16*(4+c) +: 16]  = 16'(odd1);
            v_c[16*(8+c) +: 16]  = 16'((a0 - a1 + 7) >>> 4);
            v_c[16*(12+c) +: 16] = 16'(odd3);
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_s1 <= 1'b0;
            valid_o  <= 1'b0;
        end else begin
            valid_s1 <= start_i;
            valid_o  <= valid_s1;
        end
    end

    // Payload moves only with its valid bit
    always_ff @(posedge clk_i) begin
        if (start_i) begin
            h_r     <= h_c;
            pred_s1 <= pred_i;
        end
        if (valid_s1) begin
            coeff_o <= v_c;
            pred_o  <= pred_s1;
        end
    end

endmodule

// File: design/quantize_block.sv
`timescale 1ns/1ps
`include "vp8_enc_defines.svh"

module quantize_block (
     input  logic                     clk_i
    ,input  logic                     rst_n_i
    ,input  logic                     valid_i
    ,input  vp8_enc_pkg::coeff_blk_t  coeff_i
    ,input  vp8_enc_pkg::pix_blk_t    pred_i
    ,quant_if.quant                   qp
    ,output vp8_enc_pkg::level_blk_t  levels_o
    ,output logic                     nz_o
    ,output logic                     levels_valid_o
    ,output vp8_enc_pkg::coeff_blk_t  deq_o
    ,output vp8_enc_pkg::pix_blk_t    pred_o
    ,output logic                     valid_o
);

    // Raster index of each scan position
    localparam int ZIGZAG [16] = '{0, 1, 4, 8, 5, 2, 3, 6, 9, 12, 13, 10, 7, 11, 14, 15};

    logic                  sign_c [16];
    logic [16:0]           sum_c  [16];
    logic                  pass_c [16];
    logic                  sign_r [16];
    logic [16:0]           sum_r  [16];
    logic                  pass_r [16];
    vp8_enc_pkg::pix_blk_t pred_s1;
    logic                  valid_s1;
    logic                  valid_s2;
    vp8_enc_pkg::coeff_t   lvl_c  [16];
    vp8_enc_pkg::coeff_t   deq_c  [16];
    logic                  nz_c;

    // ----------------------------------------
    // Stage 1: |coeff| + sharpen, dead zone test
    // ----------------------------------------
    always_comb begin : s1_comb
        vp8_enc_pkg::coeff_t c;
        int                  mag;
        for (int j = 0; j < 16; j++) begin
            c         = coeff_i[16*j +: 16];
            sign_c[j] = c[15];
            mag       = c[15] ? -int'(c) : int'(c);
            sum_c[j]  = 17'(mag + int'(qp.sharpen[j]));
            pass_c[j] = 32'(sum_c[j]) > qp.zthresh[j];
        end
    end

    // ----------------------------------------
    // Stage 2: level, clamp, dequantize
    // ----------------------------------------
    always_comb begin : s2_comb
        logic [39:0] acc;
        logic [22:0] mag;
        int          lvl;
        nz_c = 1'b0;
        for (int j = 0; j < 16; j++) begin
            acc = 40'(sum_r[j]) * 40'(qp.iq[j]) + 40'(qp.bias[j]);
            mag = 23'(acc >> `VP8_QFIX);
            if (mag > 23'(`VP8_MAX_LEVEL)) begin
                mag = 23'(`VP8_MAX_LEVEL);
            end
            lvl = sign_r[j] ? -int'(mag) : int'(mag);
            if (!pass_r[j]) begin
                lvl = 0;
            end
            lvl_c[j] = vp8_enc_pkg::coeff_t'(lvl);
            deq_c[j] = vp8_enc_pkg::coeff_t'(lvl * int'(qp.q[j]));
            nz_c     = nz_c | (lvl != 0);
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_s1 <= 1'b0;
            valid_s2 <= 1'b0;
        end else begin
            valid_s1 <= valid_i;
            valid_s2 <= valid_s1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            sign_r  <= sign_c;
            sum_r   <= sum_c;
            pass_r  <= pass_c;
            pred_s1 <= pred_i;
        end
        if (valid_s1) begin
            for (int n = 0; n < 16; n++) begin
                levels_o[16*n +: 16] <= lvl_c[ZIGZAG[n]];
                deq_o[16*n +: 16]    <= deq_c[n];
            end
            nz_o   <= nz_c;
            pred_o <= pred_s1;
        end
    end

    assign levels_valid_o = valid_s2;
    assign valid_o        = valid_s2;

    for (genvar g = 0; g < 16; g++) begin : g_lvl_chk
        vp8_enc_pkg::coeff_t lvl_q;
        assign lvl_q = levels_o[16*g +: 16];
        a_level_range: assert property (@(posedge clk_i) disable iff (!rst_n_i)
            levels_valid_o |-> (lvl_q <= `VP8_MAX_LEVEL) && (lvl_q >= -`VP8_MAX_LEVEL));
    end

endmodule

// File: design/idct_4x4.sv
`timescale 1ns/1ps
`include "vp8_enc_defines.svh"

module idct_4x4 (
     input  logic                     clk_i
    ,input  logic                     rst_n_i
    ,input  logic                     valid_i
    ,input  vp8_enc_pkg::coeff_blk_t  coeff_i
    ,input  vp8_enc_pkg::pix_blk_t    pred_i
    ,output vp8_enc_pkg::pix_blk_t    recon_o
    ,output logic                     done_o
);

    typedef logic signed [47:0] wide_t;

    logic signed [19:0]    vt_c [16];
    logic signed [19:0]    vt_r [16];
    vp8_enc_pkg::pix_blk_t pred_s1;
    vp8_enc_pkg::pix_blk_t recon_c;
    logic                  valid_s1;

    // Fixed point multiply, keeps product >> 16
    function automatic wide_t mul_k(input wide_t a, input wide_t k);
        wide_t p;
        p = a * k;
        return p >>> 16;
    endfunction

    // Descale, add prediction, saturate to a pixel
    function automatic vp8_enc_pkg::pixel_t clip8(input wide_t v, input vp8_enc_pkg::pixel_t p);
        wide_t s;
        s = (v >>> 3) + wide_t'(p);
        if (s < 0) begin
            return 8'd0;
        end else if (s > 255) begin
            return 8'd255;
        end
        return s[7:0];
    endfunction

    // Stage 1: vertical pass, result stored column-major
    always_comb begin : v_pass
        wide_t in0, in1, in2, in3;
        wide_t a, b, c, d;
        for (int i = 0; i < 4; i++) begin
            in0 = wide_t'($signed(coeff_i[16*i +: 16]));
            in1 = wide_t'($signed(coeff_i[16*(4+i) +: 16]));
            in2 = wide_t'($signed(coeff_i[16*(8+i) +: 16]));
            in3 = wide_t'($signed(coeff_i[16*(12+i) +: 16]));
            a = in0 + in2;
            b = in0 - in2;
            c = mul_k(in1, `VP8_IDCT_C2) - mul_k(in3, `VP8_IDCT_C1);
            d = mul_k(in1, `VP8_IDCT_C1) + mul_k(in3, `VP8_IDCT_C2);
            vt_c[4*i+0] = 20'(a + d);
            vt_c[4*i+1] = 20'(b + c);
            vt_c[4*i+2] = 20'(b - c);
            vt_c[4*i+3] = 20'(a - d);
        end
    end

    // Stage 2: horizontal pass, one output row per r
    always_comb begin : h_pass
        wide_t t0, t1, t2, t3;
        wide_t dc, a, b, c, d;
        for (int r = 0; r < 4; r++) begin
            t0 = wide_t'(vt_r[r]);
            t1 = wide_t'(vt_r[4+r]);
            t2 = wide_t'(vt_r[8+r]);
            t3 = wide_t'(vt_r[12+r]);
            dc = t0 + 4;
            a  = dc + t2;
            b  = dc - t2;
            c  = mul_k(t1, `VP8_IDCT_C2) - mul_k(t3, `VP8_IDCT_C1);
            d  = mul_k(t1, `VP8_IDCT_C1) + mul_k(t3, `VP8_IDCT_C2);
            recon_c[8*(4*r+0) +: 8] = clip8(a + d, pred_s1[8*(4*r+0) +: 8]);
            recon_c[8*(4*r+1) +: 8] = clip8(b + c, pred_s1[8*(4*r+1) +: 8]);
            recon_c[8*(4*r+2) +: 8] = clip8(b - c, pred_s1[8*(4*r+2) +: 8]);
            recon_c[8*(4*r+3) +: 8] = clip8(a - d, pred_s1[8*(4*r+3) +: 8]);
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_s1 <= 1'b0;
            done_o   <= 1'b0;
        end else begin
            valid_s1 <= valid_i;
            done_o   <= valid_s1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            vt_r    <= vt_c;
            pred_s1 <= pred_i;
        end
        if (valid_s1) begin
            recon_o <= recon_c;
        end
    end

    a_no_early_done: assert property (@(posedge clk_i) $rose(rst_n_i) |-> !done_o [*2]);

endmodule

// File: design/block_recon_top.sv
`timescale 1ns/1ps

module block_recon_top (
     input  logic                     clk_i
    ,input  logic                     rst_n_i
    ,input  logic                     start_i
    ,input  vp8_enc_pkg::pix_blk_t    src_i
    ,input  vp8_enc_pkg::pix_blk_t    pred_i
    ,input  logic                     cfg_we_i
    ,input  vp8_enc_pkg::qfield_t     cfg_field_i
    ,input  vp8_enc_pkg::coef_idx_t   cfg_idx_i
    ,input  vp8_enc_pkg::qwide_t      cfg_data_i
    ,output vp8_enc_pkg::level_blk_t  levels_o
    ,output logic                     nz_o
    ,output logic                     levels_valid_o
    ,output vp8_enc_pkg::pix_blk_t    recon_o
    ,output logic                     done_o
);

    quant_if qp_if ();

    // ----------------------------------------
    // Inter-stage buses
    // ----------------------------------------
    vp8_enc_pkg::coeff_blk_t fdct_coeff;
    vp8_enc_pkg::pix_blk_t   fdct_pred;
    logic                    fdct_valid;
    vp8_enc_pkg::coeff_blk_t deq_coeff;
    vp8_enc_pkg::pix_blk_t   deq_pred;
    logic                    deq_valid;

    quant_param_regs quant_param_regs_inst (
         .clk_i          ( clk_i          )
        ,.rst_n_i        ( rst_n_i        )
        ,.cfg_we_i       ( cfg_we_i       )
        ,.cfg_field_i    ( cfg_field_i    )
        ,.cfg_idx_i      ( cfg_idx_i      )
        ,.cfg_data_i     ( cfg_data_i     )
        ,.qp             ( qp_if.regs     )
    );

    fdct_4x4 fdct_4x4_inst (
         .clk_i          ( clk_i          )
        ,.rst_n_i        ( rst_n_i        )
        ,.start_i        ( start_i        )
        ,.src_i          ( src_i          )
        ,.pred_i         ( pred_i         )
        ,.coeff_o        ( fdct_coeff     )
        ,.pred_o         ( fdct_pred      )
        ,.valid_o        ( fdct_valid     )
    );

    quantize_block quantize_block_inst (
         .clk_i          ( clk_i          )
        ,.rst_n_i        ( rst_n_i        )
        ,.valid_i        ( fdct_valid     )
        ,.coeff_i        ( fdct_coeff     )
        ,.pred_i         ( fdct_pred      )
        ,.qp             ( qp_if.quant    )
        ,.levels_o       ( levels_o       )
        ,.nz_o           ( nz_o           )
        ,.levels_valid_o ( levels_valid_o )
        ,.deq_o          ( deq_coeff      )
        ,.pred_o         ( deq_pred       )
        ,.valid_o        ( deq_valid      )
    );

    idct_4x4 idct_4x4_inst (
         .clk_i          ( clk_i          )
        ,.rst_n_i        ( rst_n_i        )
        ,.valid_i        ( deq_valid      )
        ,.coeff_i        ( deq_coeff      )
        ,.pred_i         ( deq_pred       )
        ,.recon_o        ( recon_o        )
        ,.done_o         ( done_o         )
    );

endmodule

// File: tests/recon_model.svh
`ifndef RECON_MODEL_SVH
`define RECON_MODEL_SVH

// Shadow of the quantizer matrices as written over the config port
int unsigned mdl_q       [16];
int unsigned mdl_iq      [16];
int unsigned mdl_bias    [16];
int unsigned mdl_zthresh [16];
int unsigned mdl_sharpen [16];

// Raster position of each zigzag scan slot
localparam int SCAN_ORDER [16] = '{0, 1, 4, 8, 5, 2, 3, 6, 9, 12, 13, 10, 7, 11, 14, 15};

function automatic int pix(input vp8_enc_pkg::pix_blk_t blk, input int i);
    return int'(blk[8*i +: 8]);
endfunction

function automatic int coef(input logic [255:0] blk, input int i);
    return int'($signed(blk[16*i +: 16]));
endfunction

// ----------------------------------------
// Forward transform of src - pred
// ----------------------------------------
function automatic vp8_enc_pkg::coeff_blk_t fwd_transform(
    input vp8_enc_pkg::pix_blk_t src,
    input vp8_enc_pkg::pix_blk_t pred
);
    int tmp [16];
    int d [4];
    int a0, a1, a2, a3;
    vp8_enc_pkg::coeff_blk_t out;
    for (int r = 0; r < 4; r++) begin
        for (int c = 0; c < 4; c++) begin
            d[c] = pix(src, 4*r+c) - pix(pred, 4*r+c);
        end
        a0 = d[0] + d[3];
        a1 = d[1] + d[2];
        a2 = d[1] - d[2];
        a3 = d[0] - d[3];
        tmp[4*r+0] = (a0 + a1) * 8;
        tmp[4*r+1] = (a2 * `VP8_FDCT_K1 + a3 * `VP8_FDCT_K2 + 1812) >>> 9;
        tmp[4*r+2] = (a0 - a1) * 8;
        tmp[4*r+3] = (a3 * `VP8_FDCT_K1 - a2 * `VP8_FDCT_K2 + 937) >>> 9;
    end
    for (int c = 0; c < 4; c++) begin
        a0 = tmp[c] + tmp[12+c];
        a1 = tmp[4+c] + tmp[8+c];
        a2 = tmp[4+c] - tmp[8+c];
        a3 = tmp[c] - tmp[12+c];
        out[16*c +: 16]      = 16'((a0 + a1 + 7) >>> 4);
        out[16*(4+c) +: 16]  = 16'(((a2 * `VP8_FDCT_K1 + a3 * `VP8_FDCT_K2 + 12000) >>> 16)
                                   + ((a3 != 0) ? 1 : 0));
        out[16*(8+c) +: 16]  = 16'((a0 - a1 + 7) >>> 4);
        out[16*(12+c) +: 16] = 16'((a3 * `VP8_FDCT_K1 - a2 * `VP8_FDCT_K2 + 51000) >>> 16);
    end
    return out;
endfunction

// Levels leave in scan order, dequantized values in raster order
function automatic void quantize(
    input  vp8_enc_pkg::coeff_blk_t coeffs,
    output vp8_enc_pkg::level_blk_t levels,
    output vp8_enc_pkg::coeff_blk_t deq,
    output logic                    nz
);
    int              raster [16];
    int              c;
    longint unsigned sum;
    longint unsigned mag;
    nz = 1'b0;
    for (int j = 0; j < 16; j++) begin
        c         = coef(coeffs, j);
        sum       = (c < 0) ? -c : c;
        sum       = sum + mdl_sharpen[j];
        raster[j] = 0;
        if (sum > mdl_zthresh[j]) begin
            mag = (sum * mdl_iq[j] + mdl_bias[j]) >> `VP8_QFIX;
            if (mag > `VP8_MAX_LEVEL) begin
                mag = `VP8_MAX_LEVEL;
            end
            raster[j] = (c < 0) ? -int'(mag) : int'(mag);
        end
        deq[16*j +: 16] = 16'(raster[j] * int'(mdl_q[j]));
        nz = nz | (raster[j] != 0);
    end
    for (int n = 0; n < 16; n++) begin
        levels[16*n +: 16] = 16'(raster[SCAN_ORDER[n]]);
    end
endfunction

function automatic longint mul_c1(input longint x);
    return (x * `VP8_IDCT_C1) >>> 16;
endfunction

function automatic longint mul_c2(input longint x);
    return (x * `VP8_IDCT_C2) >>> 16;
endfunction

function automatic logic [7:0] add_clip(input longint v, input int p);
    longint s;
    s = (v >>> 3) + p;
    return (s < 0) ? 8'd0 : (s > 255) ? 8'd255 : 8'(s);
endfunction

// ----------------------------------------
// Inverse transform plus prediction
// ----------------------------------------
function automatic vp8_enc_pkg::pix_blk_t inv_transform(
    input vp8_enc_pkg::coeff_blk_t deq,
    input vp8_enc_pkg::pix_blk_t   pred
);
    longint tmp [16];
    longint a, b, c, d, dc;
    vp8_enc_pkg::pix_blk_t out;
    for (int i = 0; i < 4; i++) begin
        a = coef(deq, i) + coef(deq, 8+i);
        b = coef(deq, i) - coef(deq, 8+i);
        c = mul_c2(coef(deq, 4+i)) - mul_c1(coef(deq, 12+i));
        d = mul_c1(coef(deq, 4+i)) + mul_c2(coef(deq, 12+i));
        tmp[4*i+0] = a + d;
        tmp[4*i+1] = b + c;
        tmp[4*i+2] = b - c;
        tmp[4*i+3] = a - d;
    end
    for (int r = 0; r < 4; r++) begin
        dc = tmp[r] + 4;
        a  = dc + tmp[8+r];
        b  = dc - tmp[8+r];
        c  = mul_c2(tmp[4+r]) - mul_c1(tmp[12+r]);
        d  = mul_c1(tmp[4+r]) + mul_c2(tmp[12+r]);
        out[8*(4*r+0) +: 8] = add_clip(a + d, pix(pred, 4*r+0));
        out[8*(4*r+1) +: 8] = add_clip(b + c, pix(pred, 4*r+1));
        out[8*(4*r+2) +: 8] = add_clip(b - c, pix(pred, 4*r+2));
        out[8*(4*r+3) +: 8] = add_clip(a - d, pix(pred, 4*r+3));
    end
    return out;
endfunction

`endif

// File: tests/tb_block_recon.sv
`timescale 1ns/1ps
`include "vp8_enc_defines.svh"

module tb_block_recon;

    localparam int CLK_PERIOD   = 8;
    localparam int N_ZERO       = 8;
    localparam int N_SPACED     = 200;
    localparam int N_B2B        = 64;
    localparam int N_EDGE       = 16;
    localparam int N_BLOCKS     = N_ZERO + N_SPACED + N_B2B + 2 * N_EDGE;
    localparam int WATCHDOG_CYC = N_BLOCKS * 10 + 500;

    // How the scoreboard forms its expectation
    localparam int MODE_MODEL = 0;
    localparam int MODE_ZERO  = 1;
    localparam int MODE_CLAMP = 2;

    logic                    clk_i;
    logic                    rst_n_i;
    logic                    start_i;
    vp8_enc_pkg::pix_blk_t   src_i;
    vp8_enc_pkg::pix_blk_t   pred_i;
    logic                    cfg_we_i;
    vp8_enc_pkg::qfield_t    cfg_field_i;
    vp8_enc_pkg::coef_idx_t  cfg_idx_i;
    vp8_enc_pkg::qwide_t     cfg_data_i;
    vp8_enc_pkg::level_blk_t levels_o;
    logic                    nz_o;
    logic                    levels_valid_o;
    vp8_enc_pkg::pix_blk_t   recon_o;
    logic                    done_o;

    int unsigned lcg_state = 3;
    int          cyc;
    int          mode;
    int          errors;
    int          checks;
    int          started;
    int          lvl_seen;
    int          done_seen;
    int          test_err0;

    vp8_enc_pkg::level_blk_t exp_levels [$];
    logic                    exp_nz     [$];
    int                      exp_lcyc   [$];
    vp8_enc_pkg::pix_blk_t   exp_recon  [$];
    int                      exp_dcyc   [$];

    `include "recon_model.svh"

    block_recon_top block_recon_top_inst (.*);

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cyc++;
    end

    initial begin
        repeat (WATCHDOG_CYC) @(posedge clk_i);
        $display("Watchdog expired after %0d cycles before all tests finished", WATCHDOG_CYC);
        $display("sim failed");
        $finish;
    end

    function automatic int unsigned next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state >> 8;
    endfunction

    function automatic vp8_enc_pkg::pix_blk_t rand_pix_blk();
        vp8_enc_pkg::pix_blk_t b;
        for (int i = 0; i < 16; i++) begin
            b[8*i +: 8] = 8'(next_rand());
        end
        return b;
    endfunction

    function automatic bit levels_clamped(input vp8_enc_pkg::level_blk_t lv);
        int v;
        for (int n = 0; n < 16; n++) begin
            v = int'($signed(lv[16*n +: 16]));
            if (v != 0 && v != `VP8_MAX_LEVEL && v != -`VP8_MAX_LEVEL) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    // ----------------------------------------
    // Scoreboard at the falling edge
    // ----------------------------------------
    always @(negedge clk_i) begin : scoreboard
        vp8_enc_pkg::coeff_blk_t deq;
        vp8_enc_pkg::level_blk_t lv;
        vp8_enc_pkg::pix_blk_t   rc;
        logic                    nz;
        int                      due;
        if (rst_n_i && start_i) begin
            quantize(fwd_transform(src_i, pred_i), lv, deq, nz);
            rc = inv_transform(deq, pred_i);
            if (mode == MODE_ZERO) begin
                lv = '0;
                nz = 1'b0;
                rc = pred_i;
            end
            exp_levels.push_back(lv);
            exp_nz.push_back(nz);
            exp_recon.push_back(rc);
            exp_lcyc.push_back(cyc + 4);
            exp_dcyc.push_back(cyc + 6);
            started++;
        end
        if (levels_valid_o) begin
            lvl_seen++;
            if (exp_levels.size() == 0) begin
                errors++;
                $display("levels_valid_o high at cycle %0d with no block outstanding", cyc);
            end else begin
                lv  = exp_levels.pop_front();
                nz  = exp_nz.pop_front();
                due = exp_lcyc.pop_front();
                checks++;
                if (levels_o !== lv) begin
                    errors++;
                    $display("CHECK FAILED levels_o: expected %h, got %h", lv, levels_o);
                end
                if (nz_o !== nz) begin
                    errors++;
                    $display("CHECK FAILED nz_o: expected %h, got %h", nz, nz_o);
                end
                if (due != cyc) begin
                    errors++;
                    $display("levels_valid_o came at cycle %0d instead of %0d", cyc, due);
                end
                if (mode == MODE_CLAMP && !levels_clamped(levels_o)) begin
                    errors++;
                    $display("A nonzero level is not at the clamp magnitude %0d", `VP8_MAX_LEVEL);
                end
            end
        end
        if (done_o) begin
            done_seen++;
            if (exp_recon.size() == 0) begin
                errors++;
                $display("done_o high at cycle %0d with no block outstanding", cyc);
            end else begin
                rc  = exp_recon.pop_front();
                due = exp_dcyc.pop_front();
                checks++;
                if (recon_o !== rc) begin
                    errors++;
                    $display("CHECK FAILED recon_o: expected %h, got %h", rc, recon_o);
                end
                if (due != cyc) begin
                    errors++;
                    $display("done_o came at cycle %0d instead of %0d", cyc, due);
                end
            end
        end
    end

    // ----------------------------------------
    // Config and block drivers
    // ----------------------------------------
    task automatic write_cfg(input vp8_enc_pkg::qfield_t field, input int idx,
                             input int unsigned data);
        @(posedge clk_i);
        #1;
        cfg_we_i    = 1'b1;
        cfg_field_i = field;
        cfg_idx_i   = 4'(idx);
        cfg_data_i  = data;
        case (field)
            `VP8_QF_Q:       mdl_q[idx]       = data & 32'hffff;
            `VP8_QF_IQ:      mdl_iq[idx]      = data & 32'hffff;
            `VP8_QF_BIAS:    mdl_bias[idx]    = data;
            `VP8_QF_ZTHRESH: mdl_zthresh[idx] = data;
            default:         mdl_sharpen[idx] = data & 32'hffff;
        endcase
    endtask

    task automatic end_cfg();
        @(posedge clk_i);
        #1;
        cfg_we_i = 1'b0;
    endtask

    // iq follows q, zthresh never below sharpen
    task automatic load_random_matrices();
        int unsigned q;
        int unsigned iq;
        int unsigned sh;
        for (int j = 0; j < 16; j++) begin
            q  = 1 + next_rand() % 127;
            iq = (1 << `VP8_QFIX) / q;
            sh = next_rand() % 8;
            write_cfg(`VP8_QF_Q, j, q);
            write_cfg(`VP8_QF_IQ, j, (iq > 65535) ? 65535 : iq);
            write_cfg(`VP8_QF_BIAS, j, next_rand() % 65536);
            write_cfg(`VP8_QF_ZTHRESH, j, sh + next_rand() % 8);
            write_cfg(`VP8_QF_SHARPEN, j, sh);
        end
        end_cfg();
    endtask

    task automatic load_uniform_matrices(input int unsigned q, input int unsigned iq,
                                         input int unsigned bias, input int unsigned zthresh,
                                         input int unsigned sharpen);
        for (int j = 0; j < 16; j++) begin
            write_cfg(`VP8_QF_Q, j, q);
            write_cfg(`VP8_QF_IQ, j, iq);
            write_cfg(`VP8_QF_BIAS, j, bias);
            write_cfg(`VP8_QF_ZTHRESH, j, zthresh);
            write_cfg(`VP8_QF_SHARPEN, j, sharpen);
        end
        end_cfg();
    endtask

    task automatic send_block(input vp8_enc_pkg::pix_blk_t src,
                              input vp8_enc_pkg::pix_blk_t pred);
        @(posedge clk_i);
        #1;
        start_i = 1'b1;
        src_i   = src;
        pred_i  = pred;
    endtask

    task automatic stop_and_drain();
        @(posedge clk_i);
        #1;
        start_i = 1'b0;
        while (exp_levels.size() != 0 || exp_recon.size() != 0) begin
            @(posedge clk_i);
        end
    endtask

    task automatic finish_test(input string name);
        if (lvl_seen != started || done_seen != started) begin
            errors++;
            $display("%0d blocks started but %0d level strobes and %0d done strobes seen",
                     started, lvl_seen, done_seen);
        end
        $display("test %-16s %s (%0d errors)", name, (errors == test_err0) ? "ok" : "bad",
                 errors - test_err0);
        test_err0 = errors;
    endtask

    initial begin : main_seq
        vp8_enc_pkg::pix_blk_t blk;
        rst_n_i     = 1'b0;
        start_i     = 1'b0;
        src_i       = '0;
        pred_i      = '0;
        cfg_we_i    = 1'b0;
        cfg_field_i = '0;
        cfg_idx_i   = '0;
        cfg_data_i  = '0;
        mode        = MODE_MODEL;
        repeat (8) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;

        // Strobes must stay quiet with nothing started
        repeat (12) @(posedge clk_i);
        finish_test("reset");

        load_random_matrices();
        mode = MODE_ZERO;
        for (int i = 0; i < N_ZERO; i++) begin
            blk = rand_pix_blk();
            send_block(blk, blk);
            stop_and_drain();
        end
        finish_test("zero_residual");

        mode = MODE_MODEL;
        for (int i = 0; i < N_SPACED; i++) begin
            if (i % 50 == 0) begin
                load_random_matrices();
            end
            send_block(rand_pix_blk(), rand_pix_blk());
            stop_and_drain();
        end
        finish_test("random_spaced");

        for (int i = 0; i < N_B2B; i++) begin
            send_block(rand_pix_blk(), rand_pix_blk());
        end
        stop_and_drain();
        finish_test("back_to_back");

        mode = MODE_ZERO;
        load_uniform_matrices(16, 8192, 0, 32'hffff_ffff, 3);
        for (int i = 0; i < N_EDGE; i++) begin
            send_block(rand_pix_blk(), rand_pix_blk());
            stop_and_drain();
        end
        mode = MODE_CLAMP;
        load_uniform_matrices(16, 32'hffff, 32'h8000_0000, 0, 0);
        for (int i = 0; i < N_EDGE; i++) begin
            send_block(rand_pix_blk(), rand_pix_blk());
            stop_and_drain();
        end
        finish_test("deadzone_clamp");

        $display("blocks %0d, checks %0d, errors %0d", started, checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: flist.f
+incdir+design
+incdir+tests
design/vp8_enc_pkg.sv
design/quant_if.sv
design/quant_param_regs.sv
design/fdct_4x4.sv
design/quantize_block.sv
design/idct_4x4.sv
design/block_recon_top.sv
tests/tb_block_recon.sv
